// ==== hdl/fpu_ss_isa_pkg.sv ====
// -------------------------------------------------------------------------
// Encodings of the instructions that the offload subsystem decodes.
// Only the single-precision sign injections, the two register moves and
// word-sized FLW/FSW are covered. Every other encoding is rejected.
// -------------------------------------------------------------------------
`default_nettype none

package fpu_ss_isa_pkg;

  // Data path and register file geometry
  localparam int unsigned XLEN     = 32;
  localparam int unsigned NUM_FPR  = 32;
  localparam int unsigned SIGN_BIT = 31;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [31:0]     instr_t;

  // Instruction field types
  typedef logic [6:0] opcode_t;
  typedef logic [6:0] funct7_t;
  typedef logic [2:0] funct3_t;

  // -------------------------------------------------------------------------
  // Major opcodes
  // -------------------------------------------------------------------------
  localparam opcode_t OPC_OP_FP    = 7'b1010011;
  localparam opcode_t OPC_LOAD_FP  = 7'b0000111;
  localparam opcode_t OPC_STORE_FP = 7'b0100111;

  // Function codes under OP-FP
  localparam funct7_t F7_FSGNJ   = 7'b0010000;
  localparam funct7_t F7_FMV_X_W = 7'b1110000;
  localparam funct7_t F7_FMV_W_X = 7'b1111000;

  localparam funct3_t F3_SGNJ  = 3'b000;
  localparam funct3_t F3_SGNJN = 3'b001;
  localparam funct3_t F3_SGNJX = 3'b010;
  // Moves use a zero funct3
  localparam funct3_t F3_MV    = 3'b000;
  // Width code of FLW and FSW
  localparam funct3_t F3_WORD  = 3'b010;

  // Operations known to the execute stage
  localparam int unsigned NUM_OPS = 7;

  typedef enum logic [2:0] {
    OP_SGNJ,
    OP_SGNJN,
    OP_SGNJX,
    OP_MV_XW,
    OP_MV_WX,
    OP_LOAD,
    OP_STORE
  } fp_op_e;

endpackage

`default_nettype wire

// ==== hdl/fpu_ss_bus_pkg.sv ====
// -------------------------------------------------------------------------
// Port and stage transfer structs of the offload subsystem.
// Ids are 4 bits wide and are only carried through, never checked.
// -------------------------------------------------------------------------
`default_nettype none

package fpu_ss_bus_pkg;

  localparam int unsigned ID_WIDTH = 4;

  typedef logic [ID_WIDTH-1:0] id_t;

  // -------------------------------------------------------------------------
  // Core side
  // -------------------------------------------------------------------------
  typedef struct packed {
    fpu_ss_isa_pkg::instr_t instr;
    fpu_ss_isa_pkg::word_t  rs1;
    fpu_ss_isa_pkg::word_t  rs2;
    id_t                    id;
  } issue_req_t;

  typedef struct packed {
    logic accept;
    logic writeback;
    logic loadstore;
  } issue_resp_t;

  typedef struct packed {
    fpu_ss_isa_pkg::word_t addr;
    fpu_ss_isa_pkg::word_t wdata;
    logic                  we;
    id_t                   id;
  } mem_req_t;

  typedef struct packed {
    fpu_ss_isa_pkg::word_t rdata;
    id_t                   id;
  } mem_result_t;

  // Integer destination result
  typedef struct packed {
    fpu_ss_isa_pkg::word_t     data;
    fpu_ss_isa_pkg::reg_addr_t rd;
    id_t                       id;
    logic                      we;
  } result_t;

  // -------------------------------------------------------------------------
  // Internal stages
  // -------------------------------------------------------------------------
  typedef struct packed {
    logic                      valid;
    fpu_ss_isa_pkg::fp_op_e    op;
    fpu_ss_isa_pkg::reg_addr_t rs1;
    fpu_ss_isa_pkg::reg_addr_t rs2;
    fpu_ss_isa_pkg::reg_addr_t rd;
    fpu_ss_isa_pkg::word_t     offset;
    logic                      rd_is_fp;
  } dec_op_t;

  typedef struct packed {
    logic                      valid;
    id_t                       id;
    fpu_ss_isa_pkg::reg_addr_t rd;
    fpu_ss_isa_pkg::word_t     data;
    logic                      rd_is_fp;
  } ex_q_t;

  typedef struct packed {
    logic                      we;
    fpu_ss_isa_pkg::reg_addr_t waddr;
    fpu_ss_isa_pkg::word_t     wdata;
  } fpr_wb_t;

endpackage

`default_nettype wire

// ==== hdl/fpu_ss_decoder.sv ====
// -------------------------------------------------------------------------
// Combinational decode of one offered instruction.
// The accept response depends on the instruction word alone. The decoded
// operation is marked valid only while the core offers it.
// -------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module fpu_ss_decoder (
  input  fpu_ss_isa_pkg::instr_t      instr_i,
  input  logic                        issue_valid_i,
  output fpu_ss_bus_pkg::dec_op_t     dec_o,
  output fpu_ss_bus_pkg::issue_resp_t resp_o
);

  import fpu_ss_isa_pkg::*;

  opcode_t             opcode;
  funct7_t             funct7;
  funct3_t             funct3;
  reg_addr_t           rs2;
  logic                is_op_fp;
  logic                accept;
  logic [NUM_OPS-1:0]  match;
  fp_op_e              op_sel;
  word_t               imm_i;
  word_t               imm_s;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  assign rs2    = instr_i[24:20];

  assign is_op_fp = (opcode == OPC_OP_FP);

  // One match line per supported operation
  assign match[OP_SGNJ]  = is_op_fp && (funct7 == F7_FSGNJ) && (funct3 == F3_SGNJ);
  assign match[OP_SGNJN] = is_op_fp && (funct7 == F7_FSGNJ) && (funct3 == F3_SGNJN);
  assign match[OP_SGNJX] = is_op_fp && (funct7 == F7_FSGNJ) && (funct3 == F3_SGNJX);
  assign match[OP_MV_XW] = is_op_fp && (funct7 == F7_FMV_X_W) && (funct3 == F3_MV)
                           && (rs2 == '0);
  assign match[OP_MV_WX] = is_op_fp && (funct7 == F7_FMV_W_X) && (funct3 == F3_MV)
                           && (rs2 == '0);
  assign match[OP_LOAD]  = (opcode == OPC_LOAD_FP) && (funct3 == F3_WORD);
  assign match[OP_STORE] = (opcode == OPC_STORE_FP) && (funct3 == F3_WORD);

  assign accept = |match;

  // Sign-extended I-type and S-type offsets
  assign imm_i = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{(XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};

  always_comb begin
    op_sel = OP_SGNJ;
    for (int i = 0; i < NUM_OPS; i++) begin
      if (match[i]) begin
        op_sel = fp_op_e'(i);
      end
    end
  end

  assign dec_o.valid    = issue_valid_i & accept;
  assign dec_o.op       = op_sel;
  assign dec_o.rs1      = instr_i[19:15];
  assign dec_o.rs2      = rs2;
  assign dec_o.rd       = instr_i[11:7];
  assign dec_o.offset   = match[OP_STORE] ? imm_s : imm_i;
  assign dec_o.rd_is_fp = match[OP_SGNJ] | match[OP_SGNJN] | match[OP_SGNJX]
                        | match[OP_MV_WX] | match[OP_LOAD];

  // Only FMV.X.W writes an integer register
  assign resp_o.accept    = accept;
  assign resp_o.writeback = match[OP_MV_XW];
  assign resp_o.loadstore = match[OP_LOAD] | match[OP_STORE];

  // Encodings must not overlap
  always_comb begin
    if (issue_valid_i) begin
      assert final ($onehot0(match))
        else $error("decoder: several operations match one instruction");
    end
  end

endmodule

`default_nettype wire

// ==== hdl/fpu_ss_regfile.sv ====
// -------------------------------------------------------------------------
// Floating-point register file, two asynchronous reads and one write.
// A read of the register written in the same cycle returns the old value.
// -------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module fpu_ss_regfile (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  fpu_ss_isa_pkg::reg_addr_t raddr_a_i,
  input  fpu_ss_isa_pkg::reg_addr_t raddr_b_i,
  output fpu_ss_isa_pkg::word_t     rdata_a_o,
  output fpu_ss_isa_pkg::word_t     rdata_b_o,
  input  fpu_ss_bus_pkg::fpr_wb_t   wb_i
);

  import fpu_ss_isa_pkg::*;

  word_t regs_q [NUM_FPR];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NUM_FPR; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wb_i.we) begin
      regs_q[wb_i.waddr] <= wb_i.wdata;
    end
  end

  assign rdata_a_o = regs_q[raddr_a_i];
  assign rdata_b_o = regs_q[raddr_b_i];

endmodule

`default_nettype wire

// ==== hdl/fpu_ss_execute.sv ====
// -------------------------------------------------------------------------
// Operand read with forwarding, sign injection, moves and the memory
// request. Only the execute register is forwarded. Load data reaches the
// register file before any dependent instruction can issue.
// -------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module fpu_ss_execute (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       issue_valid_i,
  input  fpu_ss_bus_pkg::issue_req_t issue_req_i,
  input  fpu_ss_bus_pkg::dec_op_t    dec_i,
  input  logic                       stall_i,
  input  fpu_ss_bus_pkg::fpr_wb_t    wb_i,
  output logic                       issue_ready_o,
  output fpu_ss_bus_pkg::ex_q_t      ex_q_o,
  output logic                       mem_valid_o,
  input  logic                       mem_ready_i,
  output fpu_ss_bus_pkg::mem_req_t   mem_req_o
);

  import fpu_ss_isa_pkg::*;
  import fpu_ss_bus_pkg::*;

  word_t    fpr_a;
  word_t    fpr_b;
  word_t    op_a;
  word_t    op_b;
  word_t    ex_data;
  logic     issue_fire;
  logic     is_mem;
  logic     mem_start;
  ex_q_t    ex_q;
  logic     mem_valid_q;
  mem_req_t mem_req_q;

  assign issue_ready_o = ~stall_i & ~mem_valid_q;
  assign issue_fire    = issue_valid_i & issue_ready_o;
  assign is_mem        = (dec_i.op == OP_LOAD) || (dec_i.op == OP_STORE);
  assign mem_start     = issue_fire & dec_i.valid & is_mem;

  fpu_ss_regfile i_regfile (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .raddr_a_i (dec_i.rs1),
    .raddr_b_i (dec_i.rs2),
    .rdata_a_o (fpr_a),
    .rdata_b_o (fpr_b),
    .wb_i      (wb_i)
  );

  // The execute register writes back one edge after capture
  always_comb begin
    op_a = fpr_a;
    op_b = fpr_b;
    if (ex_q.valid && ex_q.rd_is_fp && (ex_q.rd == dec_i.rs1)) begin
      op_a = ex_q.data;
    end
    if (ex_q.valid && ex_q.rd_is_fp && (ex_q.rd == dec_i.rs2)) begin
      op_b = ex_q.data;
    end
  end

  // -------------------------------------------------------------------------
  // Sign injection and moves
  // -------------------------------------------------------------------------
  always_comb begin
    ex_data = op_a;
    case (dec_i.op)
      OP_SGNJ:  ex_data[SIGN_BIT] = op_b[SIGN_BIT];
      OP_SGNJN: ex_data[SIGN_BIT] = ~op_b[SIGN_BIT];
      OP_SGNJX: ex_data[SIGN_BIT] = op_a[SIGN_BIT] ^ op_b[SIGN_BIT];
      OP_MV_WX: ex_data = issue_req_i.rs1;
      // FMV.X.W passes rs1 unchanged
      default:  ex_data = op_a;
    endcase
  end

  // rd is kept for memory ops too, the pending load picks it up
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ex_q <= '0;
    end else begin
      ex_q.valid <= issue_fire & dec_i.valid & ~is_mem;
      if (issue_fire) begin
        ex_q.id       <= issue_req_i.id;
        ex_q.rd       <= dec_i.rd;
        ex_q.data     <= ex_data;
        ex_q.rd_is_fp <= dec_i.rd_is_fp;
      end
    end
  end

  assign ex_q_o = ex_q;

  // -------------------------------------------------------------------------
  // Memory request
  // -------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mem_valid_q <= 1'b0;
    end else if (mem_start) begin
      mem_valid_q <= 1'b1;
    end else if (mem_ready_i) begin
      mem_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_start) begin
      mem_req_q.addr  <= issue_req_i.rs1 + dec_i.offset;
      mem_req_q.wdata <= op_b;
      mem_req_q.we    <= (dec_i.op == OP_STORE);
      mem_req_q.id    <= issue_req_i.id;
    end
  end

  assign mem_valid_o = mem_valid_q;
  assign mem_req_o   = mem_req_q;

  a_mem_req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_valid_o && !mem_ready_i |=> mem_valid_o && $stable(mem_req_o))
    else $error("execute: memory request changed before handshake");

endmodule

`default_nettype wire

// ==== hdl/fpu_ss_result.sv ====
// -------------------------------------------------------------------------
// Result port hold, pending load record and register write select.
// Assumes at most one load in flight and a load result strictly after
// its request handshake.
// -------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module fpu_ss_result (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  fpu_ss_bus_pkg::ex_q_t       ex_q_i,
  input  logic                        mem_fire_i,
  input  fpu_ss_bus_pkg::mem_req_t    mem_req_i,
  input  logic                        mem_result_valid_i,
  input  fpu_ss_bus_pkg::mem_result_t mem_result_i,
  input  logic                        result_ready_i,
  output logic                        result_valid_o,
  output fpu_ss_bus_pkg::result_t     result_o,
  output fpu_ss_bus_pkg::fpr_wb_t     wb_o,
  output logic                        stall_o
);

  import fpu_ss_isa_pkg::*;
  import fpu_ss_bus_pkg::*;

  logic      ex_int;
  result_t   ex_res;
  logic      hold_q;
  result_t   hold_res_q;
  logic      load_pend_q;
  reg_addr_t load_rd_q;

  // -------------------------------------------------------------------------
  // Integer result port
  // -------------------------------------------------------------------------
  assign ex_int = ex_q_i.valid & ~ex_q_i.rd_is_fp;

  assign ex_res.data = ex_q_i.data;
  assign ex_res.rd   = ex_q_i.rd;
  assign ex_res.id   = ex_q_i.id;
  assign ex_res.we   = 1'b1;

  // ex_q lives one cycle, a refused result moves into the hold register
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      hold_q <= 1'b0;
    end else begin
      hold_q <= result_valid_o & ~result_ready_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ex_int && !hold_q) begin
      hold_res_q <= ex_res;
    end
  end

  assign result_valid_o = ex_int | hold_q;
  assign result_o       = hold_q ? hold_res_q : ex_res;

  // -------------------------------------------------------------------------
  // Pending load
  // -------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      load_pend_q <= 1'b0;
    end else if (mem_fire_i && !mem_req_i.we) begin
      load_pend_q <= 1'b1;
    end else if (mem_result_valid_i) begin
      load_pend_q <= 1'b0;
    end
  end

  // No issue while the request waits, so ex_q still holds the load's rd
  always_ff @(posedge clk_i) begin
    if (mem_fire_i && !mem_req_i.we) begin
      load_rd_q <= ex_q_i.rd;
    end
  end

  assign stall_o = (result_valid_o & ~result_ready_i) | load_pend_q;

  // Register write, load data first
  always_comb begin
    wb_o.we    = ex_q_i.valid & ex_q_i.rd_is_fp;
    wb_o.waddr = ex_q_i.rd;
    wb_o.wdata = ex_q_i.data;
    if (mem_result_valid_i) begin
      wb_o.we    = 1'b1;
      wb_o.waddr = load_rd_q;
      wb_o.wdata = mem_result_i.rdata;
    end
  end

  a_load_pending: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_result_valid_i |-> load_pend_q)
    else $error("result: memory result without a pending load");

  a_wb_collision: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(mem_result_valid_i && ex_q_i.valid && ex_q_i.rd_is_fp))
    else $error("result: load data and execute result write together");

endmodule

`default_nettype wire

// ==== hdl/fpu_ss_top.sv ====
// -------------------------------------------------------------------------
// Floating-point offload subsystem beside an integer core.
// One instruction in execute and at most one memory access at a time.
// No exceptions, no commit interface and no FP CSR.
// -------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module fpu_ss_top (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  // Issue
  input  logic                        issue_valid_i,
  output logic                        issue_ready_o,
  input  fpu_ss_bus_pkg::issue_req_t  issue_req_i,
  output fpu_ss_bus_pkg::issue_resp_t issue_resp_o,
  // Memory request and result
  output logic                        mem_valid_o,
  input  logic                        mem_ready_i,
  output fpu_ss_bus_pkg::mem_req_t    mem_req_o,
  input  logic                        mem_result_valid_i,
  input  fpu_ss_bus_pkg::mem_result_t mem_result_i,
  // Integer result
  output logic                        result_valid_o,
  input  logic                        result_ready_i,
  output fpu_ss_bus_pkg::result_t     result_o
);

  import fpu_ss_bus_pkg::*;

  dec_op_t dec_op;
  ex_q_t   ex_q;
  fpr_wb_t fpr_wb;
  logic    stall;
  logic    mem_fire;

  assign mem_fire = mem_valid_o & mem_ready_i;

  fpu_ss_decoder i_decoder (
    .instr_i       (issue_req_i.instr),
    .issue_valid_i (issue_valid_i),
    .dec_o         (dec_op),
    .resp_o        (issue_resp_o)
  );

  fpu_ss_execute i_execute (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .issue_valid_i (issue_valid_i),
    .issue_req_i   (issue_req_i),
    .dec_i         (dec_op),
    .stall_i       (stall),
    .wb_i          (fpr_wb),
    .issue_ready_o (issue_ready_o),
    .ex_q_o        (ex_q),
    .mem_valid_o   (mem_valid_o),
    .mem_ready_i   (mem_ready_i),
    .mem_req_o     (mem_req_o)
  );

  fpu_ss_result i_result (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .ex_q_i             (ex_q),
    .mem_fire_i         (mem_fire),
    .mem_req_i          (mem_req_o),
    .mem_result_valid_i (mem_result_valid_i),
    .mem_result_i       (mem_result_i),
    .result_ready_i     (result_ready_i),
    .result_valid_o     (result_valid_o),
    .result_o           (result_o),
    .wb_o               (fpr_wb),
    .stall_o            (stall)
  );

endmodule

`default_nettype wire

// ==== verification/fpu_ss_tb_model.svh ====
// -------------------------------------------------------------------------
// In-order reference model of the FP register file and of the supported
// instructions. It is included inside the testbench module after the
// package imports. The load image is 256 words, indexed by addr[9:2].
// -------------------------------------------------------------------------
`ifndef FPU_SS_TB_MODEL_SVH
`define FPU_SS_TB_MODEL_SVH

// Instruction kinds of the stimulus, the last three are invalid encodings
localparam int K_SGNJ    = 0;
localparam int K_SGNJN   = 1;
localparam int K_SGNJX   = 2;
localparam int K_MV_XW   = 3;
localparam int K_MV_WX   = 4;
localparam int K_LOAD    = 5;
localparam int K_STORE   = 6;
localparam int K_BAD_F3  = 7;
localparam int K_BAD_MV  = 8;
localparam int K_BAD_OP  = 9;
localparam int NUM_KINDS = 10;

word_t    fpr_m [NUM_FPR];
word_t    mem_data [256];
result_t  exp_results [$];
mem_req_t exp_mem [$];

task automatic init_model();
  logic [7:0] ia;
  for (int r = 0; r < NUM_FPR; r++) begin
    fpr_m[r] = '0;
  end
  // Every byte of a word depends on the whole index
  for (int a = 0; a < 256; a++) begin
    ia = 8'(a);
    mem_data[a] = {ia, ~ia, 8'(ia * 8'd37), ia ^ 8'h5a};
  end
endtask

// Applies one instruction in issue order and queues the expected transfers
task automatic model_apply(input int kind, input issue_req_t req, input reg_addr_t rd,
                           input reg_addr_t rs1, input reg_addr_t rs2,
                           input logic [11:0] imm, output issue_resp_t exp);
  word_t    a;
  word_t    b;
  word_t    addr;
  result_t  res;
  mem_req_t mreq;
  a    = fpr_m[rs1];
  b    = fpr_m[rs2];
  addr = req.rs1 + {{20{imm[11]}}, imm};
  exp.accept    = (kind < K_BAD_F3);
  exp.writeback = (kind == K_MV_XW);
  exp.loadstore = (kind == K_LOAD) || (kind == K_STORE);
  mreq.addr  = addr;
  mreq.wdata = b;
  mreq.we    = (kind == K_STORE);
  mreq.id    = req.id;
  case (kind)
    K_SGNJ:  fpr_m[rd] = {b[31], a[30:0]};
    K_SGNJN: fpr_m[rd] = {~b[31], a[30:0]};
    K_SGNJX: fpr_m[rd] = {a[31] ^ b[31], a[30:0]};
    K_MV_WX: fpr_m[rd] = req.rs1;
    K_MV_XW: begin
      res.data = a;
      res.rd   = rd;
      res.id   = req.id;
      res.we   = 1'b1;
      exp_results.push_back(res);
    end
    K_LOAD: begin
      exp_mem.push_back(mreq);
      fpr_m[rd] = mem_data[addr[9:2]];
    end
    K_STORE: exp_mem.push_back(mreq);
    // Invalid words leave the state alone
    default: ;
  endcase
endtask

`endif

// ==== verification/fpu_ss_tb.sv ====
// -------------------------------------------------------------------------
// Random testbench of the FP offload subsystem against an in-order model.
// Memory ready, load latency and result ready are randomized. The run
// ends with a read-back of all 32 FP registers through FMV.X.W.
// -------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module fpu_ss_tb;

  import fpu_ss_isa_pkg::*;
  import fpu_ss_bus_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int RST_CYCLES = 3;
  localparam int NUM_INSTR  = 400;
  localparam int WAIT_LIMIT = 200;
  localparam int SEED       = 3233;

  logic        clk_i;
  logic        rst_n_i;
  logic        issue_valid_i;
  logic        issue_ready_o;
  issue_req_t  issue_req_i;
  issue_resp_t issue_resp_o;
  logic        mem_valid_o;
  logic        mem_ready_i;
  mem_req_t    mem_req_o;
  logic        mem_result_valid_i;
  mem_result_t mem_result_i;
  logic        result_valid_o;
  logic        result_ready_i;
  result_t     result_o;

  integer  seed;
  integer  bp_seed;
  int      n_pass;
  int      n_fail;
  bit      timed_out;
  // Memory responder state
  bit      load_busy;
  int      load_wait;
  word_t   load_data;
  id_t     load_id;
  // Result port state of the previous edge
  bit      res_stalled;
  result_t res_last;

  `include "fpu_ss_tb_model.svh"

  fpu_ss_top i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever begin
      #(CLK_PERIOD / 2);
      clk_i = ~clk_i;
    end
  end

  // -------------------------------------------------------------------------
  // Compare tasks
  // -------------------------------------------------------------------------
  task automatic check_resp(input string name, input issue_resp_t exp,
                            input issue_resp_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
      n_fail++;
    end else begin
      $display("ok %s", name);
      n_pass++;
    end
  endtask

  task automatic check_result(input string name, input result_t exp, input result_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      n_fail++;
    end else begin
      $display("ok %s", name);
      n_pass++;
    end
  endtask

  // wdata only matters for stores
  task automatic check_mem_req(input string name, input mem_req_t exp, input mem_req_t act);
    if (act.addr !== exp.addr || act.we !== exp.we || act.id !== exp.id
        || (exp.we && act.wdata !== exp.wdata)) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      n_fail++;
    end else begin
      $display("ok %s", name);
      n_pass++;
    end
  endtask

  // -------------------------------------------------------------------------
  // Stimulus
  // -------------------------------------------------------------------------
  function automatic instr_t encode(input int kind, input reg_addr_t rd,
                                    input reg_addr_t rs1, input reg_addr_t rs2,
                                    input logic [11:0] imm);
    case (kind)
      K_SGNJ:   return {F7_FSGNJ, rs2, rs1, F3_SGNJ, rd, OPC_OP_FP};
      K_SGNJN:  return {F7_FSGNJ, rs2, rs1, F3_SGNJN, rd, OPC_OP_FP};
      K_SGNJX:  return {F7_FSGNJ, rs2, rs1, F3_SGNJX, rd, OPC_OP_FP};
      K_MV_XW:  return {F7_FMV_X_W, 5'd0, rs1, F3_MV, rd, OPC_OP_FP};
      K_MV_WX:  return {F7_FMV_W_X, 5'd0, rs1, F3_MV, rd, OPC_OP_FP};
      K_LOAD:   return {imm, rs1, F3_WORD, rd, OPC_LOAD_FP};
      K_STORE:  return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OPC_STORE_FP};
      K_BAD_F3: return {F7_FSGNJ, rs2, rs1, 3'b011, rd, OPC_OP_FP};
      // FMV.X.W with a nonzero rs2 field
      K_BAD_MV: return {F7_FMV_X_W, rs2 | 5'd1, rs1, F3_MV, rd, OPC_OP_FP};
      default:  return {imm, rs1, 3'b000, rd, 7'b0110011};
    endcase
  endfunction

  task automatic issue_instr(input int kind, input reg_addr_t rd, input reg_addr_t rs1,
                             input reg_addr_t rs2, input logic [11:0] imm,
                             input string name);
    issue_req_t  req;
    issue_resp_t exp;
    int          cycles;
    req.instr = encode(kind, rd, rs1, rs2, imm);
    req.rs1   = $random(seed);
    req.rs2   = $random(seed);
    req.id    = id_t'($random(seed));
    model_apply(kind, req, rd, rs1, rs2, imm, exp);
    issue_valid_i <= 1'b1;
    issue_req_i   <= req;
    cycles = 0;
    do begin
      @(posedge clk_i);
      cycles++;
    end while (!issue_ready_o && cycles < WAIT_LIMIT);
    if (issue_ready_o) begin
      check_resp(name, exp, issue_resp_o);
    end else begin
      $display("ERROR: %s was not accepted within %0d cycles", name, WAIT_LIMIT);
      timed_out = 1'b1;
    end
  endtask

  // Registers f0..f15 only, so dependencies are frequent
  task automatic issue_random(input int idx);
    int          kind;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    logic [11:0] imm;
    kind = {$random(seed)} % NUM_KINDS;
    rd   = reg_addr_t'($random(seed) & 15);
    rs1  = reg_addr_t'($random(seed) & 15);
    rs2  = reg_addr_t'($random(seed) & 15);
    imm  = 12'($random(seed));
    issue_instr(kind, rd, rs1, rs2, imm, $sformatf("instr %0d kind %0d", idx, kind));
    // Half of the instructions follow back to back
    if ($random(seed) & 1) begin
      issue_valid_i <= 1'b0;
      repeat (1 + {$random(seed)} % 2) @(posedge clk_i);
    end
  endtask

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while ((exp_results.size() != 0 || exp_mem.size() != 0 || load_busy)
           && cycles < WAIT_LIMIT) begin
      @(posedge clk_i);
      cycles++;
    end
    if (exp_results.size() != 0 || exp_mem.size() != 0 || load_busy) begin
      $display("ERROR: outstanding results or memory requests never completed");
      timed_out = 1'b1;
    end
  endtask

  // -------------------------------------------------------------------------
  // Memory responder and back-pressure
  // -------------------------------------------------------------------------
  always @(posedge clk_i) begin : responder
    mem_req_t exp_req;
    mem_ready_i        <= ({$random(bp_seed)} % 4) != 0;
    result_ready_i     <= ({$random(bp_seed)} % 4) != 0;
    mem_result_valid_i <= 1'b0;
    if (rst_n_i && mem_valid_o && mem_ready_i) begin
      if (exp_mem.size() == 0) begin
        $display("ERROR: memory request without a matching instruction");
        n_fail++;
      end else begin
        exp_req = exp_mem.pop_front();
        check_mem_req($sformatf("mem request id %0d", exp_req.id), exp_req, mem_req_o);
      end
      if (!mem_req_o.we) begin
        load_busy = 1'b1;
        load_wait = {$random(bp_seed)} % 4;
        load_data = mem_data[mem_req_o.addr[9:2]];
        load_id   = mem_req_o.id;
      end
    end
    // A zero wait still answers one edge after the handshake
    if (load_busy) begin
      if (load_wait == 0) begin
        mem_result_valid_i <= 1'b1;
        mem_result_i.rdata <= load_data;
        mem_result_i.id    <= load_id;
        load_busy = 1'b0;
      end else begin
        load_wait--;
      end
    end
  end

  // Result port and issue stall monitor
  always @(posedge clk_i) begin : result_monitor
    result_t exp_res;
    if (rst_n_i) begin
      if (res_stalled && (!result_valid_o || result_o !== res_last)) begin
        $display("ERROR: result changed or dropped before the core took it");
        n_fail++;
      end
      if (result_valid_o && result_ready_i) begin
        if (exp_results.size() == 0) begin
          $display("ERROR: result delivered with none expected");
          n_fail++;
        end else begin
          exp_res = exp_results.pop_front();
          check_result($sformatf("result x%0d id %0d", exp_res.rd, exp_res.id),
                       exp_res, result_o);
        end
      end
      if (issue_valid_i && issue_ready_o
          && (mem_valid_o || (result_valid_o && !result_ready_i))) begin
        $display("ERROR: instruction accepted while the subsystem was stalled");
        n_fail++;
      end
      res_stalled = result_valid_o && !result_ready_i;
      res_last    = result_o;
    end
  end

  // -------------------------------------------------------------------------
  // Main sequence
  // -------------------------------------------------------------------------
  initial begin
    seed               = SEED;
    bp_seed            = SEED + 1;
    n_pass             = 0;
    n_fail             = 0;
    timed_out          = 1'b0;
    load_busy          = 1'b0;
    load_wait          = 0;
    res_stalled        = 1'b0;
    rst_n_i            = 1'b0;
    issue_valid_i      = 1'b0;
    issue_req_i        = '0;
    mem_ready_i        = 1'b0;
    mem_result_valid_i = 1'b0;
    mem_result_i       = '0;
    result_ready_i     = 1'b0;
    init_model();
    repeat (RST_CYCLES) @(posedge clk_i);
    rst_n_i <= 1'b1;
    for (int i = 0; i < NUM_INSTR && !timed_out; i++) begin
      issue_random(i);
    end
    // Read back the whole register file
    for (int r = 0; r < NUM_FPR && !timed_out; r++) begin
      issue_instr(K_MV_XW, reg_addr_t'(r), reg_addr_t'(r), '0, '0,
                  $sformatf("readback f%0d", r));
    end
    issue_valid_i <= 1'b0;
    if (!timed_out) begin
      wait_drained();
    end
    $display("checks passed: %0d, failed: %0d, timeout: %0d", n_pass, n_fail, timed_out);
    if (n_fail == 0 && !timed_out) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+verification
hdl/fpu_ss_isa_pkg.sv
hdl/fpu_ss_bus_pkg.sv
hdl/fpu_ss_decoder.sv
hdl/fpu_ss_regfile.sv
hdl/fpu_ss_execute.sv
hdl/fpu_ss_result.sv
hdl/fpu_ss_top.sv
verification/fpu_ss_tb.sv
